// ==== source/bus_pkg.sv ====
package bus_pkg;

	// Caravel wishbone master side
	localparam int ADDR_W = 28;
	localparam int DATA_W = 32;
	localparam int SEL_W = DATA_W / 8;

	// Slave-local word address, the bits below the slave index
	localparam int OFFSET_W = 24;

	// Cycles from an accepted strobe to its ack or error
	localparam int RESP_LATENCY = 1;

	// Slave index in the top address bits
	// All other codes are unmapped and answered with error
	typedef enum logic [ADDR_W-OFFSET_W-1:0] {
		CORE0_MEM = 4'd0,
		CORE1_MEM = 4'd1,
		VIDEO_MEM = 4'd2
	} slave_e;

endpackage

// ==== source/mem_pkg.sv ====
package mem_pkg;

	// One SRAM bank, 512 words of 32 bits
	localparam int WORD_ADDR_W = 9;
	localparam int BANK_WORDS = 1 << WORD_ADDR_W;

	// Write mask granularity
	localparam int BYTE_W = 8;

endpackage

// ==== source/sram_bank.sv ====
`timescale 1ns/1ps

module sram_bank (
	input  logic clk_i,
	input  logic csb_i,
	input  logic web_i,
	input  logic [bus_pkg::SEL_W-1:0] wmask_i,
	input  logic [mem_pkg::WORD_ADDR_W-1:0] addr_i,
	input  logic [bus_pkg::DATA_W-1:0] din_i,
	output logic [bus_pkg::DATA_W-1:0] dout_o
);

	logic [bus_pkg::DATA_W-1:0] mem [mem_pkg::BANK_WORDS];

	// Chip select and write enable are active low like the macro
	always_ff @(posedge clk_i) begin
		if (!csb_i) begin
			if (!web_i) begin
				// Only the masked byte lanes are written
				for (int i = 0; i < bus_pkg::SEL_W; i++) begin
					if (wmask_i[i]) begin
						mem[addr_i][i*mem_pkg::BYTE_W +: mem_pkg::BYTE_W] <=
							din_i[i*mem_pkg::BYTE_W +: mem_pkg::BYTE_W];
					end
				end
			end else begin
				// Read word shows up one cycle after the enable
				dout_o <= mem[addr_i];
			end
		end
	end

endmodule

// ==== source/local_memory.sv ====
`timescale 1ns/1ps

module local_memory #(
	parameter int BANK_COUNT = 2
) (
	input  logic wb_clk_i,
	input  logic rst_n_i,
	input  logic wb_cyc_i,
	input  logic wb_stb_i,
	input  logic wb_we_i,
	input  logic [bus_pkg::SEL_W-1:0] wb_sel_i,
	input  logic [bus_pkg::OFFSET_W-1:0] wb_adr_i,
	input  logic [bus_pkg::DATA_W-1:0] wb_data_i,
	output logic wb_ack_o,
	output logic [bus_pkg::DATA_W-1:0] wb_data_o
);

	localparam int BANK_SEL_W = (BANK_COUNT > 1) ? $clog2(BANK_COUNT) : 1;

	logic access;
	logic [BANK_SEL_W-1:0] bank_index;
	logic [mem_pkg::WORD_ADDR_W-1:0] word_index;
	logic [BANK_SEL_W-1:0] bank_q;
	logic ack_q;
	logic [bus_pkg::DATA_W-1:0] bank_dout [BANK_COUNT];

	assign access = wb_cyc_i && wb_stb_i;

	// Word bits first, then the bank bits
	// Anything above them aliases
	assign word_index = wb_adr_i[mem_pkg::WORD_ADDR_W-1:0];
	assign bank_index = BANK_SEL_W'(wb_adr_i[mem_pkg::WORD_ADDR_W +: BANK_SEL_W] % BANK_COUNT);

	for (genvar b = 0; b < BANK_COUNT; b++) begin : gen_bank
		sram_bank sram_bank_i (
			.clk_i(wb_clk_i),
			.csb_i(!(access && bank_index == BANK_SEL_W'(b))),
			.web_i(!wb_we_i),
			.wmask_i(wb_sel_i),
			.addr_i(word_index),
			.din_i(wb_data_i),
			.dout_o(bank_dout[b])
		);
	end

	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	// Remembers which bank answers in the ack cycle
	always_ff @(posedge wb_clk_i) begin
		if (access) begin
			bank_q <= bank_index;
		end
	end

	assign wb_ack_o = ack_q;
	assign wb_data_o = bank_dout[bank_q];

endmodule

// ==== source/wb_interconnect.sv ====
`timescale 1ns/1ps

module wb_interconnect (
	input  logic wb_clk_i,
	input  logic rst_n_i,

	// Caravel master
	input  logic master_cyc_i,
	input  logic master_stb_i,
	input  logic master_we_i,
	input  logic [bus_pkg::SEL_W-1:0] master_sel_i,
	input  logic [bus_pkg::ADDR_W-1:0] master_adr_i,
	input  logic [bus_pkg::DATA_W-1:0] master_data_i,
	output logic master_ack_o,
	output logic master_error_o,
	output logic [bus_pkg::DATA_W-1:0] master_data_o,

	// Shared by all slaves
	output logic slave_cyc_o,
	output logic slave_we_o,
	output logic [bus_pkg::SEL_W-1:0] slave_sel_o,
	output logic [bus_pkg::OFFSET_W-1:0] slave_adr_o,
	output logic [bus_pkg::DATA_W-1:0] slave_data_o,

	// Per slave strobe and response
	output logic core0_stb_o,
	output logic core1_stb_o,
	output logic video_stb_o,
	input  logic core0_ack_i,
	input  logic [bus_pkg::DATA_W-1:0] core0_data_i,
	input  logic core1_ack_i,
	input  logic [bus_pkg::DATA_W-1:0] core1_data_i,
	input  logic video_ack_i,
	input  logic [bus_pkg::DATA_W-1:0] video_data_i
);

	bus_pkg::slave_e slave_index;
	bus_pkg::slave_e resp_slave_q;
	logic access;
	logic unmapped;
	logic error_q;

	assign access = master_cyc_i && master_stb_i;
	assign slave_index = bus_pkg::slave_e'(master_adr_i[bus_pkg::ADDR_W-1:bus_pkg::OFFSET_W]);
	assign unmapped = !(slave_index inside {bus_pkg::CORE0_MEM, bus_pkg::CORE1_MEM,
		bus_pkg::VIDEO_MEM});

	assign slave_cyc_o = master_cyc_i;
	assign slave_we_o = master_we_i;
	assign slave_sel_o = master_sel_i;
	assign slave_adr_o = master_adr_i[bus_pkg::OFFSET_W-1:0];
	assign slave_data_o = master_data_i;

	// Only the addressed slave sees the strobe
	assign core0_stb_o = master_stb_i && slave_index == bus_pkg::CORE0_MEM;
	assign core1_stb_o = master_stb_i && slave_index == bus_pkg::CORE1_MEM;
	assign video_stb_o = master_stb_i && slave_index == bus_pkg::VIDEO_MEM;

	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			resp_slave_q <= bus_pkg::CORE0_MEM;
			error_q <= 1'b0;
		end else begin
			resp_slave_q <= slave_index;
			error_q <= access && unmapped;
		end
	end

	// Response comes from whichever slave was strobed last cycle
	always_comb begin
		case (resp_slave_q)
			bus_pkg::CORE0_MEM: begin
				master_ack_o = core0_ack_i;
				master_data_o = core0_data_i;
			end
			bus_pkg::CORE1_MEM: begin
				master_ack_o = core1_ack_i;
				master_data_o = core1_data_i;
			end
			bus_pkg::VIDEO_MEM: begin
				master_ack_o = video_ack_i;
				master_data_o = video_data_i;
			end
			default: begin
				master_ack_o = 1'b0;
				master_data_o = '0;
			end
		endcase
	end

	assign master_error_o = error_q;

endmodule

// ==== source/experiar_soc.sv ====
`timescale 1ns/1ps

module experiar_soc #(
	parameter int CORE_BANKS = 2,
	parameter int VIDEO_BANKS = 4
) (
	input  logic wb_clk_i,
	input  logic rst_n_i,

	// Caravel wishbone master
	input  logic wb_cyc_i,
	input  logic wb_stb_i,
	input  logic wb_we_i,
	input  logic [bus_pkg::SEL_W-1:0] wb_sel_i,
	input  logic [bus_pkg::ADDR_W-1:0] wb_adr_i,
	input  logic [bus_pkg::DATA_W-1:0] wb_data_i,
	output logic wb_ack_o,
	output logic wb_error_o,
	output logic [bus_pkg::DATA_W-1:0] wb_data_o
);

	// Slave side, shared
	logic slave_cyc;
	logic slave_we;
	logic [bus_pkg::SEL_W-1:0] slave_sel;
	logic [bus_pkg::OFFSET_W-1:0] slave_adr;
	logic [bus_pkg::DATA_W-1:0] slave_data;

	// Slave side, one set per memory
	logic core0_stb;
	logic core0_ack;
	logic [bus_pkg::DATA_W-1:0] core0_data;
	logic core1_stb;
	logic core1_ack;
	logic [bus_pkg::DATA_W-1:0] core1_data;
	logic video_stb;
	logic video_ack;
	logic [bus_pkg::DATA_W-1:0] video_data;

	wb_interconnect wb_interconnect_i (
		.wb_clk_i(wb_clk_i),
		.rst_n_i(rst_n_i),
		.master_cyc_i(wb_cyc_i),
		.master_stb_i(wb_stb_i),
		.master_we_i(wb_we_i),
		.master_sel_i(wb_sel_i),
		.master_adr_i(wb_adr_i),
		.master_data_i(wb_data_i),
		.master_ack_o(wb_ack_o),
		.master_error_o(wb_error_o),
		.master_data_o(wb_data_o),
		.slave_cyc_o(slave_cyc),
		.slave_we_o(slave_we),
		.slave_sel_o(slave_sel),
		.slave_adr_o(slave_adr),
		.slave_data_o(slave_data),
		.core0_stb_o(core0_stb),
		.core1_stb_o(core1_stb),
		.video_stb_o(video_stb),
		.core0_ack_i(core0_ack),
		.core0_data_i(core0_data),
		.core1_ack_i(core1_ack),
		.core1_data_i(core1_data),
		.video_ack_i(video_ack),
		.video_data_i(video_data)
	);

	local_memory #(.BANK_COUNT(CORE_BANKS)) core0_memory (
		.wb_clk_i(wb_clk_i),
		.rst_n_i(rst_n_i),
		.wb_cyc_i(slave_cyc),
		.wb_stb_i(core0_stb),
		.wb_we_i(slave_we),
		.wb_sel_i(slave_sel),
		.wb_adr_i(slave_adr),
		.wb_data_i(slave_data),
		.wb_ack_o(core0_ack),
		.wb_data_o(core0_data)
	);

	local_memory #(.BANK_COUNT(CORE_BANKS)) core1_memory (
		.wb_clk_i(wb_clk_i),
		.rst_n_i(rst_n_i),
		.wb_cyc_i(slave_cyc),
		.wb_stb_i(core1_stb),
		.wb_we_i(slave_we),
		.wb_sel_i(slave_sel),
		.wb_adr_i(slave_adr),
		.wb_data_i(slave_data),
		.wb_ack_o(core1_ack),
		.wb_data_o(core1_data)
	);

	// Frame buffer gets twice the banks
	local_memory #(.BANK_COUNT(VIDEO_BANKS)) video_memory (
		.wb_clk_i(wb_clk_i),
		.rst_n_i(rst_n_i),
		.wb_cyc_i(slave_cyc),
		.wb_stb_i(video_stb),
		.wb_we_i(slave_we),
		.wb_sel_i(slave_sel),
		.wb_adr_i(slave_adr),
		.wb_data_i(slave_data),
		.wb_ack_o(video_ack),
		.wb_data_o(video_data)
	);

endmodule

// ==== verif/soc_checker.sv ====
`timescale 1ns/1ps

module soc_checker #(
	parameter int CORE_BANKS = 2,
	parameter int VIDEO_BANKS = 4
) (
	input  logic clk_i,
	input  logic cyc_i,
	input  logic stb_i,
	input  logic we_i,
	input  logic [bus_pkg::SEL_W-1:0] sel_i,
	input  logic [bus_pkg::ADDR_W-1:0] adr_i,
	input  logic [bus_pkg::DATA_W-1:0] data_i,
	input  logic ack_i,
	input  logic error_i,
	input  logic [bus_pkg::DATA_W-1:0] rdata_i,
	output int check_count_o,
	output int error_count_o
);

	// Word model keyed by slave, bank and word, with the bits written so far
	logic [bus_pkg::DATA_W-1:0] model_data [int];
	logic [bus_pkg::DATA_W-1:0] model_known [int];
	// Expected response per strobe, oldest first
	logic exp_error_q [$];
	logic [bus_pkg::DATA_W-1:0] exp_data_q [$];
	logic [bus_pkg::DATA_W-1:0] exp_bits_q [$];
	int checks = 0;
	int errors = 0;

	assign check_count_o = checks;
	assign error_count_o = errors;

	// Bank bits wrap modulo the bank count, upper offset bits alias
	function automatic int word_key(logic [bus_pkg::ADDR_W-1:0] adr);
		bus_pkg::slave_e slave;
		int banks;
		int bank;
		slave = bus_pkg::slave_e'(adr[bus_pkg::ADDR_W-1:bus_pkg::OFFSET_W]);
		banks = (slave == bus_pkg::VIDEO_MEM) ? VIDEO_BANKS : CORE_BANKS;
		bank = int'(adr[bus_pkg::OFFSET_W-1:mem_pkg::WORD_ADDR_W]) % banks;
		return (int'(slave) * 8 + bank) * mem_pkg::BANK_WORDS
			+ int'(adr[mem_pkg::WORD_ADDR_W-1:0]);
	endfunction

	task automatic record_strobe();
		bus_pkg::slave_e slave;
		int key;
		logic [bus_pkg::DATA_W-1:0] lanes;
		slave = bus_pkg::slave_e'(adr_i[bus_pkg::ADDR_W-1:bus_pkg::OFFSET_W]);
		key = word_key(adr_i);
		for (int i = 0; i < bus_pkg::SEL_W; i++) begin
			lanes[i*8 +: 8] = {8{sel_i[i]}};
		end
		if (!(slave == bus_pkg::CORE0_MEM || slave == bus_pkg::CORE1_MEM ||
			slave == bus_pkg::VIDEO_MEM)) begin
			// Unmapped, no memory changes
			exp_error_q.push_back(1'b1);
			exp_data_q.push_back('0);
			exp_bits_q.push_back('0);
		end else begin
			if (!model_data.exists(key)) begin
				model_data[key] = '0;
				model_known[key] = '0;
			end
			if (we_i) begin
				model_data[key] = (model_data[key] & ~lanes) | (data_i & lanes);
				model_known[key] = model_known[key] | lanes;
			end
			exp_error_q.push_back(1'b0);
			exp_data_q.push_back(we_i ? '0 : model_data[key]);
			exp_bits_q.push_back(we_i ? '0 : model_known[key]);
		end
	endtask

	task automatic check_response();
		logic exp_error;
		logic [bus_pkg::DATA_W-1:0] exp_data;
		logic [bus_pkg::DATA_W-1:0] exp_bits;
		if (exp_error_q.size() == 0) begin
			if (ack_i !== 1'b0 || error_i !== 1'b0) begin
				$display("At %0t ack or error came with no strobe outstanding", $time);
				errors++;
			end
		end else begin
			exp_error = exp_error_q.pop_front();
			exp_data = exp_data_q.pop_front();
			exp_bits = exp_bits_q.pop_front();
			checks++;
			if (ack_i !== 1'b1 && error_i !== 1'b1) begin
				$display("At %0t a strobe got no ack and no error one cycle later", $time);
				errors++;
			end else if (ack_i !== !exp_error || error_i !== exp_error) begin
				$display("ERR %0t: ack %b error %b, expected error %b",
					$time, ack_i, error_i, exp_error);
				errors++;
			end else if (((rdata_i ^ exp_data) & exp_bits) !== '0) begin
				$display("ERR %0t: read %h, model %h on bits %h",
					$time, rdata_i, exp_data, exp_bits);
				errors++;
			end
		end
	endtask

	// Outputs answer the strobe seen one falling edge earlier
	always @(negedge clk_i) begin
		check_response();
		if (cyc_i && stb_i) begin
			record_strobe();
		end
	end

endmodule

// ==== verif/tb_experiar_soc.sv ====
`timescale 1ns/1ps

module tb_experiar_soc;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 4;
	localparam int CORE_BANKS = 2;
	localparam int VIDEO_BANKS = 4;
	// Strobes of all tests together
	localparam int TOTAL_STROBES = 24 + 36 + 200 + 24 + 24;
	localparam int MARGIN_CYCLES = 40;

	logic clk = 1'b0;
	logic rst_n;
	logic cyc;
	logic stb;
	logic we;
	logic [bus_pkg::SEL_W-1:0] sel;
	logic [bus_pkg::ADDR_W-1:0] adr;
	logic [bus_pkg::DATA_W-1:0] wdata;
	logic ack;
	logic error;
	logic [bus_pkg::DATA_W-1:0] rdata;
	int check_count;
	int error_count;
	int test_count = 0;
	int checks_at_start;
	int errors_at_start;
	int banks;
	int bank_bits;
	logic [3:0] slave;
	logic [bus_pkg::OFFSET_W-1:0] offset;
	logic [mem_pkg::WORD_ADDR_W-1:0] word;

	experiar_soc #(.CORE_BANKS(CORE_BANKS), .VIDEO_BANKS(VIDEO_BANKS)) experiar_soc_i (
		.wb_clk_i(clk),
		.rst_n_i(rst_n),
		.wb_cyc_i(cyc),
		.wb_stb_i(stb),
		.wb_we_i(we),
		.wb_sel_i(sel),
		.wb_adr_i(adr),
		.wb_data_i(wdata),
		.wb_ack_o(ack),
		.wb_error_o(error),
		.wb_data_o(rdata)
	);

	soc_checker #(.CORE_BANKS(CORE_BANKS), .VIDEO_BANKS(VIDEO_BANKS)) soc_checker_i (
		.clk_i(clk),
		.cyc_i(cyc),
		.stb_i(stb),
		.we_i(we),
		.sel_i(sel),
		.adr_i(adr),
		.data_i(wdata),
		.ack_i(ack),
		.error_i(error),
		.rdata_i(rdata),
		.check_count_o(check_count),
		.error_count_o(error_count)
	);

	initial begin
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	// One strobe for one cycle, changed 1 ns after the edge
	task automatic issue(input logic write, input logic [3:0] mask,
		input logic [27:0] addr, input logic [31:0] data);
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		sel = mask;
		adr = addr;
		wdata = data;
		@(posedge clk);
		#1;
	endtask

	task automatic go_idle();
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		@(posedge clk);
		#1;
	endtask

	task automatic start_test();
		checks_at_start = check_count;
		errors_at_start = error_count;
	endtask

	// The idle cycle lets the last response get compared
	task automatic end_test(input string name);
		go_idle();
		test_count++;
		$display("test %0d %s: %0d checks, %0d errors", test_count, name,
			check_count - checks_at_start, error_count - errors_at_start);
	endtask

	// Small address pool so random reads hit earlier writes
	function automatic logic [23:0] pool_offset();
		return {12'($urandom_range(0, 3)), 3'($urandom_range(0, 7)), 9'($urandom_range(0, 15))};
	endfunction

	initial begin
		void'($urandom(59));
		rst_n = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		sel = '0;
		adr = '0;
		wdata = '0;
		start_test();
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
		end_test("reset quiet");

		start_test();
		for (int s = 0; s < 3; s++) begin
			for (int i = 0; i < 4; i++) begin
				offset = 24'($urandom);
				issue(1'b1, 4'hf, {4'(s), offset}, $urandom);
				issue(1'b0, 4'hf, {4'(s), offset}, '0);
			end
		end
		end_test("write read");

		start_test();
		for (int s = 0; s < 3; s++) begin
			for (int i = 0; i < 4; i++) begin
				offset = 24'($urandom);
				issue(1'b1, 4'hf, {4'(s), offset}, $urandom);
				issue(1'b1, 4'($urandom), {4'(s), offset}, $urandom);
				issue(1'b0, 4'hf, {4'(s), offset}, '0);
			end
		end
		end_test("byte select");

		start_test();
		repeat (200) begin
			slave = 4'($urandom_range(0, 2));
			issue(1'($urandom), 4'($urandom), {slave, pool_offset()}, $urandom);
		end
		end_test("back to back");

		// Unmapped write between a write and a read of the same offset
		start_test();
		repeat (8) begin
			slave = 4'($urandom_range(0, 2));
			offset = pool_offset();
			issue(1'b1, 4'hf, {slave, offset}, $urandom);
			issue(1'($urandom), 4'hf, {4'($urandom_range(3, 15)), offset}, $urandom);
			issue(1'b0, 4'hf, {slave, offset}, '0);
		end
		end_test("unmapped");

		start_test();
		for (int s = 0; s < 3; s += 2) begin
			banks = (s == 2) ? VIDEO_BANKS : CORE_BANKS;
			repeat (6) begin
				word = 9'($urandom);
				bank_bits = $urandom_range(0, 7);
				issue(1'b1, 4'hf, {4'(s), 12'($urandom), 3'(bank_bits), word}, $urandom);
				bank_bits = (bank_bits + banks) % 8;
				issue(1'b0, 4'hf, {4'(s), 12'($urandom), 3'(bank_bits), word}, '0);
			end
		end
		end_test("bank alias");

		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
		if (error_count == 0 && check_count > 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	initial begin
		#((TOTAL_STROBES + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
		$display("Watchdog expired before all tests finished");
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== Bender.yml ====
package:
  name: experiar_soc

sources:
  - source/bus_pkg.sv
  - source/mem_pkg.sv
  - source/sram_bank.sv
  - source/local_memory.sv
  - source/wb_interconnect.sv
  - source/experiar_soc.sv
  - target: test
    files:
      - verif/soc_checker.sv
      - verif/tb_experiar_soc.sv

// ==== experiar_soc.f ====
source/bus_pkg.sv
source/mem_pkg.sv
source/sram_bank.sv
source/local_memory.sv
source/wb_interconnect.sv
source/experiar_soc.sv
verif/soc_checker.sv
verif/tb_experiar_soc.sv
